// File: sources.f
+incdir+source
source/controlPkg.sv
source/instrDecoder.sv
source/phaseSequencer.sv
source/controlEncoder.sv
source/controlUnit.sv
tests/controlUnitTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module controlUnitTb -o controlUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/controlUnitSim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1

// File: tests/controlUnitTb.sv
`timescale 1ns/1ps
`include "control_config.svh"

module controlUnitTb;
  import controlPkg::*;

  typedef struct packed {
    instrClass_t              kind;
    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`OFFSET_WIDTH-1:0] offset;
  } instr_t;

  // Expected behavior of the instruction held in the IR
  typedef struct packed {
    logic       isAlu;
    aluOp_t     aluOp;
    aluSrcB_t   srcB;
    regDst_t    dst;
    logic       taken;
    logic [7:0] period; // Cycles until the next IR write
  } expect_t;

  logic                     clk;
  logic                     reset;
  logic [`OPCODE_WIDTH-1:0] opcode;
  logic [`OFFSET_WIDTH-1:0] offset;
  aluFlags_t                flags;
  ctrlWord_t                ctrl;
  logic                     rstOut;

  instr_t     instrQ[$];
  expect_t    expected = '0;
  logic       started = 1'b0;
  logic       irSeen = 1'b0;
  logic       timedOut = 1'b0;
  logic [7:0] sinceIr = '0;
  int         errors = 0;
  int         testsRun = 0;
  int         testsFailed = 0;

  controlUnit controlUnit_i (
    .clk    (clk),
    .reset  (reset),
    .opcode (opcode),
    .offset (offset),
    .flags  (flags),
    .ctrl   (ctrl),
    .rstOut (rstOut)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (ctrl.irWrite) begin
      sinceIr <= 8'd1;
    end else if (sinceIr != 8'hff) begin
      sinceIr <= sinceIr + 8'd1; // Saturates if fetch stalls
    end
  end

  function automatic void reportError(input string msg);
    errors++;
    $display("** Error at %0d ns: %s", $time, msg);
  endfunction

  resetQuiet: assert property (@(posedge clk) started && $past(reset) |->
      rstOut && !(ctrl.pcWrite || ctrl.irWrite || ctrl.regWrite || ctrl.abWrite ||
      ctrl.aluOutWrite))
    else reportError("rstOut low or a strobe high in the reset phase");
  resetReleased: assert property (@(posedge clk) disable iff (reset)
      started && !$past(reset) |-> !rstOut)
    else reportError("rstOut still high after the reset phase");
  // Three cycles of PC + 4, then PC and IR load together
  fetchPair: assert property (@(posedge clk) disable iff (reset)
      ctrl.irWrite |-> ctrl.pcWrite && ctrl.pcSource == pcAluOut &&
      $past(ctrl.aluOutWrite, 3) && !$past(ctrl.aluOutWrite, 4))
    else reportError("irWrite not paired with pcWrite after three PC + 4 cycles");
  abFollows: assert property (@(posedge clk) disable iff (reset)
      ctrl.abWrite == $past(ctrl.irWrite))
    else reportError("abWrite not one cycle after irWrite");
  regWriteTime: assert property (@(posedge clk) disable iff (reset)
      ctrl.regWrite == ($past(ctrl.abWrite, 3) && expected.isAlu))
    else reportError("regWrite at the wrong cycle or for a non-ALU instruction");
  aluSetup: assert property (@(posedge clk) disable iff (reset)
      ctrl.regWrite |-> $past(ctrl.aluOutWrite) && $past(ctrl.aluSrcA) == srcAReg &&
      $past(ctrl.aluOp) == expected.aluOp && $past(ctrl.aluSrcB) == expected.srcB &&
      ctrl.regDst == expected.dst)
    else reportError("wrong ALU setup or regDst around regWrite");
  branchTake: assert property (@(posedge clk) disable iff (reset)
      ctrl.pcWrite == (ctrl.irWrite || ($past(ctrl.abWrite, 4) && expected.taken)))
    else reportError("pcWrite does not match fetch or the branch condition");
  // The IR model loads the next instruction before this sample
  fetchPeriod: assert property (@(posedge clk) disable iff (reset)
      ctrl.irWrite && $past(irSeen) |-> sinceIr == $past(expected.period))
    else reportError("irWrite period wrong for the previous instruction");

  function automatic instr_t makeInstr(input instrClass_t kind);
    instr_t      instr;
    logic [31:0] r;
    r = $urandom();
    instr.kind = kind;
    instr.offset = r[15:0]; // Random registers and immediate
    case (kind)
      classAdd, classSub: begin
        instr.opcode = opRtype;
        instr.offset[`FUNCT_WIDTH-1:0] = (kind == classAdd) ? functAdd : functSub;
      end
      classAddi: instr.opcode = opAddi;
      classBeq:  instr.opcode = opBeq;
      classBne:  instr.opcode = opBne;
      classBle:  instr.opcode = opBle;
      classBgt:  instr.opcode = opBgt;
      default: begin
        // Unsupported jump opcode or R-type AND
        instr.opcode = r[16] ? 6'h02 : opRtype;
        instr.offset[`FUNCT_WIDTH-1:0] = 6'h24;
      end
    endcase
    return instr;
  endfunction

  // Loads the IR and the ALU flags, filler no-op when the queue is empty
  task automatic loadNext();
    instr_t      instr;
    logic [31:0] r;
    instr = (instrQ.size() != 0) ? instrQ.pop_front() : makeInstr(classNone);
    r = $urandom();
    opcode = instr.opcode;
    offset = instr.offset;
    flags.eq = r[0];
    flags.gt = r[1];
    expected.isAlu = instr.kind inside {classAdd, classSub, classAddi};
    expected.aluOp = (instr.kind == classSub) ? aluSub : aluAdd;
    expected.srcB = (instr.kind == classAddi) ? srcBImm : srcBReg;
    expected.dst = (instr.kind == classAddi) ? dstRt : dstRd;
    case (instr.kind)
      classBeq: expected.taken = r[0];
      classBne: expected.taken = !r[0];
      classBle: expected.taken = !r[1];
      classBgt: expected.taken = r[1];
      default:  expected.taken = 1'b0;
    endcase
    expected.period = expected.isAlu ? 8'd9 : (instr.kind == classNone) ? 8'd6 : 8'd10;
    irSeen = 1'b1;
  endtask

  // Feeds the queue until its last instruction has completed
  task automatic runTest(input string name);
    int   errBefore;
    int   cycles;
    int   limit;
    logic done;
    errBefore = errors;
    limit = 12 * (instrQ.size() + 2);
    cycles = 0;
    done = 1'b0;
    if (timedOut) begin
      $display("Test %s skipped after an earlier timeout", name);
    end else begin
      while (!done && cycles < limit) begin
        @(negedge clk);
        cycles++;
        if (ctrl.irWrite) begin
          done = (instrQ.size() == 0);
          loadNext();
        end
      end
      if (!done) begin
        timedOut = 1'b1;
        $display("Timeout: test %s saw no instruction fetch within %0d cycles", name, limit);
      end
      testsRun++;
      if (!done || errors != errBefore) begin
        testsFailed++;
        $display("Test %s failed with %0d errors", name, errors - errBefore);
      end else begin
        $display("Test %s ok after %0d cycles", name, cycles);
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    void'($urandom(36));
    clk = 1'b0;
    reset = 1'b1;
    opcode = '0;
    offset = '0;
    flags = '0;
    @(negedge clk);
    started = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    runTest("reset");

    for (int i = 0; i < 2; i++) begin
      instrQ.push_back(makeInstr(classAdd));
      instrQ.push_back(makeInstr(classSub));
      instrQ.push_back(makeInstr(classAddi));
    end
    runTest("alu");

    for (int i = 0; i < 4; i++) begin
      instrQ.push_back(makeInstr(classBeq));
      instrQ.push_back(makeInstr(classBne));
      instrQ.push_back(makeInstr(classBle));
      instrQ.push_back(makeInstr(classBgt));
    end
    runTest("branch");

    for (int i = 0; i < 4; i++) begin
      instrQ.push_back(makeInstr(classNone));
    end
    runTest("unsupported");

    for (int i = 0; i < 40; i++) begin
      r = $urandom();
      instrQ.push_back(makeInstr(instrClass_t'(r[2:0])));
    end
    runTest("stream");

    @(negedge clk); // Period of the last stream instruction is sampled here

    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             testsRun, testsFailed, errors);
    if (errors == 0 && testsFailed == 0 && !timedOut) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ps
`include "control_config.svh"

module controlUnit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`OPCODE_WIDTH-1:0]   opcode,
  input  logic [`OFFSET_WIDTH-1:0]   offset,
  input  controlPkg::aluFlags_t      flags,
  output controlPkg::ctrlWord_t      ctrl,
  output logic                       rstOut
);
  import controlPkg::*;

  instrClass_t            instrClass;
  instrClass_t            curClass;
  phase_t                 phase;
  logic [`STEP_WIDTH-1:0] step;

  instrDecoder instrDecoder_i (
    .opcode     (opcode_t'(opcode)),
    .funct      (funct_t'(offset[`FUNCT_WIDTH-1:0])), // Low bits of offset
    .instrClass (instrClass)
  );

  phaseSequencer phaseSequencer_i (
    .clk        (clk),
    .reset      (reset),
    .instrClass (instrClass),
    .phase      (phase),
    .step       (step),
    .curClass   (curClass)
  );

  controlEncoder controlEncoder_i (
    .phase    (phase),
    .step     (step),
    .curClass (curClass),
    .flags    (flags),
    .ctrl     (ctrl),
    .rstOut   (rstOut)
  );

endmodule

// File: source/controlEncoder.sv
`timescale 1ns/1ps
`include "control_config.svh"

module controlEncoder (
  input  controlPkg::phase_t      phase,
  input  logic [`STEP_WIDTH-1:0]  step,
  input  controlPkg::instrClass_t curClass,
  input  controlPkg::aluFlags_t   flags,
  output controlPkg::ctrlWord_t   ctrl,
  output logic                    rstOut
);
  import controlPkg::*;

  localparam logic [`STEP_WIDTH-1:0] irStep = `STEP_WIDTH'(`FETCH_IR_STEP);
  localparam logic [`STEP_WIDTH-1:0] abStep = `STEP_WIDTH'(`FETCH_AB_STEP);

  // Execute steps
  localparam logic [`STEP_WIDTH-1:0] aluStep = `STEP_WIDTH'(0);
  localparam logic [`STEP_WIDTH-1:0] writeBackStep = `STEP_WIDTH'(1);
  localparam logic [`STEP_WIDTH-1:0] targetStep = `STEP_WIDTH'(0);
  localparam logic [`STEP_WIDTH-1:0] compareStep = `STEP_WIDTH'(1);
  localparam logic [`STEP_WIDTH-1:0] takeStep = `STEP_WIDTH'(2);

  logic isBranch;
  logic isAluOp;
  logic takeBranch;

  assign isBranch = curClass inside {classBeq, classBne, classBle, classBgt};
  assign isAluOp  = curClass inside {classAdd, classSub, classAddi};

  // Branch condition from the compare flags
  always_comb begin
    case (curClass)
      classBeq: takeBranch = flags.eq;
      classBne: takeBranch = !flags.eq;
      classBle: takeBranch = !flags.gt;
      classBgt: takeBranch = flags.gt;
      default:  takeBranch = 1'b0;
    endcase
  end

  assign rstOut = (phase == phaseReset);

  always_comb begin
    ctrl = '0; // Reset phase and idle steps show nothing
    case (phase)
      phaseFetch: begin
        if (step < irStep) begin
          // PC + 4 while memory is read
          ctrl.aluOutWrite = 1'b1;
          ctrl.aluOp       = aluAdd;
          ctrl.aluSrcA     = srcAPc;
          ctrl.aluSrcB     = srcBFour;
          ctrl.pcSource    = pcAluResult;
        end else if (step == irStep) begin
          ctrl.pcWrite  = 1'b1;
          ctrl.irWrite  = 1'b1;
          ctrl.pcSource = pcAluOut;
        end else if (step == abStep) begin
          ctrl.abWrite = 1'b1; // Register file read into A and B
        end
      end
      phaseExecute: begin
        if (isAluOp) begin
          if (step == aluStep) begin
            ctrl.aluOutWrite = 1'b1;
            ctrl.aluSrcA     = srcAReg;
            ctrl.aluSrcB     = (curClass == classAddi) ? srcBImm : srcBReg;
            ctrl.aluOp       = (curClass == classSub) ? aluSub : aluAdd;
          end else if (step == writeBackStep) begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = (curClass == classAddi) ? dstRt : dstRd;
          end
        end else if (isBranch) begin
          if (step == targetStep) begin
            // Branch target into ALUOut
            ctrl.aluOutWrite = 1'b1;
            ctrl.aluOp       = aluAdd;
            ctrl.aluSrcA     = srcAPc;
            ctrl.aluSrcB     = srcBBranch;
          end else if (step == compareStep || step == takeStep) begin
            ctrl.aluOp    = aluCompare;
            ctrl.aluSrcA  = srcAReg;
            ctrl.aluSrcB  = srcBReg;
            ctrl.pcSource = pcAluOut;
            ctrl.pcWrite  = (step == takeStep) && takeBranch; // Flags settled by now
          end
        end
      end
      default: begin
      end
    endcase
  end

  // PC update and register write never share a cycle
  always_comb begin
    assert (!(ctrl.regWrite && ctrl.pcWrite))
      else $error("controlEncoder: regWrite and pcWrite both high in %s", phase.name());
  end

endmodule

// File: source/phaseSequencer.sv
`timescale 1ns/1ps
`include "control_config.svh"

module phaseSequencer (
  input  logic                        clk,
  input  logic                        reset,
  input  controlPkg::instrClass_t     instrClass,
  output controlPkg::phase_t          phase,
  output logic [`STEP_WIDTH-1:0]      step,
  output controlPkg::instrClass_t     curClass
);
  import controlPkg::*;

  localparam logic [`STEP_WIDTH-1:0] decodeStep = `STEP_WIDTH'(`FETCH_DECODE_STEP);
  localparam logic [`STEP_WIDTH-1:0] aluLastStep = `STEP_WIDTH'(2);
  localparam logic [`STEP_WIDTH-1:0] branchLastStep = `STEP_WIDTH'(3);

  logic [`STEP_WIDTH-1:0] lastStep;

  // Branches need one more cycle for the conditional PC write
  always_comb begin
    case (curClass)
      classBeq, classBne, classBle, classBgt: lastStep = branchLastStep;
      default:                                lastStep = aluLastStep;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase    <= phaseReset;
      step     <= '0;
      curClass <= classNone;
    end else begin
      case (phase)
        phaseReset: begin
          phase <= phaseFetch; // First clock with reset low
          step  <= '0;
        end
        phaseFetch: begin
          if (step == decodeStep) begin
            curClass <= instrClass;
            step     <= '0;
            // No-ops go straight back to fetch
            if (instrClass == classNone) begin
              phase <= phaseFetch;
            end else begin
              phase <= phaseExecute;
            end
          end else begin
            step <= step + 1'b1;
          end
        end
        phaseExecute: begin
          if (step == lastStep) begin
            phase <= phaseFetch;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        default: begin
          phase <= phaseReset; // Illegal encoding, recover through reset
          step  <= '0;
        end
      endcase
    end
  end

  // Fetch never runs past its decode step
  assert property (@(posedge clk) disable iff (reset)
    phase == phaseFetch |-> step <= decodeStep)
    else $error("phaseSequencer: fetch step %0d out of range", step);

  // Every new phase starts counting from zero
  assert property (@(posedge clk) disable iff (reset)
    $changed(phase) |-> step == '0)
    else $error("phaseSequencer: entered %s at step %0d", phase.name(), step);

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`include "control_config.svh"

module instrDecoder (
  input  controlPkg::opcode_t     opcode,
  input  controlPkg::funct_t      funct,
  output controlPkg::instrClass_t instrClass
);
  import controlPkg::*;

  always_comb begin
    case (opcode)
      opRtype: begin
        // R-type needs funct as well
        case (funct)
          functAdd: instrClass = classAdd;
          functSub: instrClass = classSub;
          default:  instrClass = classNone;
        endcase
      end
      opAddi:  instrClass = classAddi;
      opBeq:   instrClass = classBeq;
      opBne:   instrClass = classBne;
      opBle:   instrClass = classBle;
      opBgt:   instrClass = classBgt;
      default: instrClass = classNone; // Unsupported, runs as a no-op
    endcase
  end

  // Garbage in the IR must still give a defined class
  always_comb begin
    assert (!$isunknown(instrClass))
      else $error("instrDecoder: unknown class for opcode %b", opcode);
  end

endmodule

// File: source/controlPkg.sv
package controlPkg;

  // Opcodes handled by this control unit
  typedef enum logic [5:0] {
    opRtype = 6'b000000,
    opBeq   = 6'b000100,
    opBne   = 6'b000101,
    opBle   = 6'b000110,
    opBgt   = 6'b000111,
    opAddi  = 6'b001000
  } opcode_t;

  typedef enum logic [5:0] {
    functAdd = 6'b100000,
    functSub = 6'b100010
  } funct_t;

  typedef enum logic [2:0] {
    classNone,
    classAdd,
    classSub,
    classAddi,
    classBeq,
    classBne,
    classBle,
    classBgt
  } instrClass_t;

  typedef enum logic [1:0] {
    phaseReset,
    phaseFetch,
    phaseExecute
  } phase_t;

  // Datapath mux and ALU encodings
  typedef enum logic [2:0] {
    aluNone    = 3'd0,
    aluAdd     = 3'd1,
    aluSub     = 3'd2,
    aluCompare = 3'd7
  } aluOp_t;

  typedef enum logic [1:0] {
    srcAPc  = 2'd0,
    srcAReg = 2'd1
  } aluSrcA_t;

  typedef enum logic [1:0] {
    srcBReg    = 2'd0,
    srcBFour   = 2'd1,
    srcBImm    = 2'd2,
    srcBBranch = 2'd3 // Shifted offset
  } aluSrcB_t;

  typedef enum logic [1:0] {
    pcNone      = 2'd0,
    pcAluResult = 2'd1,
    pcAluOut    = 2'd2
  } pcSource_t;

  typedef enum logic {
    dstRt = 1'b0,
    dstRd = 1'b1
  } regDst_t;

  typedef struct packed {
    logic eq;
    logic gt;
  } aluFlags_t;

  typedef struct packed {
    logic      pcWrite;
    logic      irWrite;
    logic      regWrite;
    logic      abWrite;
    logic      aluOutWrite;
    aluOp_t    aluOp;
    aluSrcA_t  aluSrcA;
    aluSrcB_t  aluSrcB;
    regDst_t   regDst;
    pcSource_t pcSource;
  } ctrlWord_t;

endpackage

// File: source/control_config.svh
`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

// Instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6
`define OFFSET_WIDTH 16 // FUNCT sits in the low bits

// Step counter and the fixed fetch steps
`define STEP_WIDTH 3
`define FETCH_IR_STEP 3
`define FETCH_AB_STEP 4
`define FETCH_DECODE_STEP 5

`endif
